// ==== Bender.yml ====
package:
  name: obi_vp

sources:
  - files:
      - src/obi_vp_pkg.sv
      - src/obi_resp_fsm.sv
      - src/obi_ram.sv
      - src/vp_timer.sv
      - src/vp_irq_merge.sv
      - src/obi_vp_top.sv
  - target: test
    files:
      - dv/obi_vp_sva.sv
      - dv/tb_obi_vp.sv

// ==== compile.f ====
src/obi_vp_pkg.sv
src/obi_resp_fsm.sv
src/obi_ram.sv
src/vp_timer.sv
src/vp_irq_merge.sv
src/obi_vp_top.sv
dv/obi_vp_sva.sv
dv/tb_obi_vp.sv

// ==== dv/obi_vp_sva.sv ====
// ---------------------------------------------------------------------
// Concurrent checks on the OBI port and the reset state
// Bound into every obi_vp_top instance by the bind below
// ---------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module obi_vp_sva #(
    parameter int unsigned RESP_LATENCY = 2
) (
    input  wire logic                           clk_i,
    input  wire logic                           arst_n_i,
    input  wire logic                           req_i,
    input  wire logic                           gnt_o,
    input  wire logic                           rvalid_o,
    input  wire logic [obi_vp_pkg::IRQ_W-1:0]   irq_i,
    input  wire logic [obi_vp_pkg::IRQ_W-1:0]   irq_o,
    input  wire logic                           debug_req_i,
    input  wire logic                           debug_req_o
);

    logic        accept;
    int unsigned busy_cnt;

    assign accept = req_i && gnt_o;

    // Wait cycles left before the response slot
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_cnt <= 0;
        end else if (accept) begin
            busy_cnt <= RESP_LATENCY - 1;
        end else if (busy_cnt != 0) begin
            busy_cnt <= busy_cnt - 1;
        end
    end

    rvalid_after_grant: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        accept |-> ##RESP_LATENCY rvalid_o)
        else $error("rvalid_o missing RESP_LATENCY cycles after a grant");

    rvalid_only_for_grant: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        rvalid_o |-> $past(accept, RESP_LATENCY))
        else $error("rvalid_o without a grant RESP_LATENCY cycles earlier");

    // One transaction outstanding
    no_grant_when_busy: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        gnt_o |-> (busy_cnt == 0))
        else $error("gnt_o high while a response is still pending");

    quiet_after_reset: assert property (@(posedge clk_i)
        $rose(arst_n_i) |-> !rvalid_o && (debug_req_i || !debug_req_o)
                            && ((irq_i != '0) || (irq_o == '0)))
        else $error("outputs not idle right after reset");

endmodule : obi_vp_sva

bind obi_vp_top obi_vp_sva #(
    .RESP_LATENCY (RESP_LATENCY)
) obi_vp_sva_i (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .req_i       (req_i),
    .gnt_o       (gnt_o),
    .rvalid_o    (rvalid_o),
    .irq_i       (irq_i),
    .irq_o       (irq_o),
    .debug_req_i (debug_req_i),
    .debug_req_o (debug_req_o)
);

`default_nettype wire

// ==== dv/tb_obi_vp.sv ====
// ---------------------------------------------------------------------
// Testbench for the OBI memory and virtual-peripheral subsystem
// Random OBI traffic from an LCG is checked every cycle against a model
// of the RAM, the response timing, the VP timers and the IRQ merge
// ---------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module tb_obi_vp;

    import obi_vp_pkg::*;

    // Same values as the DUT defaults
    localparam int unsigned RAM_AW    = 12;
    localparam int unsigned LAT       = 2;
    localparam int unsigned N_OPS     = 400;
    localparam int unsigned GNT_LIMIT = LAT + 4;
    localparam int unsigned WATCHDOG  = N_OPS * (LAT + 70 + 4) + 100;
    localparam logic [ADDR_W-1:0] VP_BASE = ADDR_W'(1) << RAM_AW;

    logic                clk_i = 1'b0;
    logic                arst_n_i;
    logic                req_i;
    logic                gnt_o;
    logic [ADDR_W-1:0]   addr_i;
    logic                we_i;
    logic [DATA_W/8-1:0] be_i;
    logic [DATA_W-1:0]   wdata_i;
    logic                rvalid_o;
    logic [DATA_W-1:0]   rdata_o;
    logic [IRQ_W-1:0]    irq_i;
    logic                irq_ack_i;
    logic [IRQ_ID_W-1:0] irq_id_i;
    logic [IRQ_W-1:0]    irq_o;
    logic                debug_req_i;
    logic                debug_req_o;

    // ---------------------------------------------------------------
    // Model state
    // ---------------------------------------------------------------
    logic [31:0]         lcg_state = 32'd81716;
    logic [DATA_W-1:0]   shadow [2**(RAM_AW-2)];
    logic [63:0]         written = '0;
    logic [IRQ_W-1:0]    pend_m = '0;
    logic                dbg_m = 1'b0;
    int unsigned         irq_due = 0;
    int unsigned         dbg_due = 0;
    logic [IRQ_ID_W-1:0] irq_line_m = '0;
    logic [IRQ_ID_W-1:0] last_line = '0;
    // Expected responses hold grant cycle and read data in request order
    int unsigned         exp_cyc_q [$];
    logic [DATA_W-1:0]   exp_data_q [$];
    int unsigned         cyc = 0;
    int unsigned         errors = 0;
    int unsigned         checks = 0;
    int unsigned         grants = 0;
    int unsigned         resps = 0;

    always #20 clk_i = ~clk_i;

    obi_vp_top #(
        .RAM_ADDR_WIDTH (RAM_AW),
        .RESP_LATENCY   (LAT)
    ) obi_vp_top_i (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .req_i       (req_i),
        .gnt_o       (gnt_o),
        .addr_i      (addr_i),
        .we_i        (we_i),
        .be_i        (be_i),
        .wdata_i     (wdata_i),
        .rvalid_o    (rvalid_o),
        .rdata_o     (rdata_o),
        .irq_i       (irq_i),
        .irq_ack_i   (irq_ack_i),
        .irq_id_i    (irq_id_i),
        .irq_o       (irq_o),
        .debug_req_i (debug_req_i),
        .debug_req_o (debug_req_o)
    );

    function automatic logic [31:0] rand_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int unsigned rand_below(input int unsigned n);
        logic [31:0] r;
        r = rand_next();
        // Upper LCG bits are the stronger ones
        return (r >> 8) % n;
    endfunction

    task automatic finish_run();
        $display("tb_obi_vp: %0d errors in %0d checks, %0d responses", errors, checks, resps);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    endtask

    // ---------------------------------------------------------------
    // Stimulus
    // ---------------------------------------------------------------
    // One clock edge with fresh external IRQ, ack and debug inputs
    task automatic next_edge();
        @(posedge clk_i);
        irq_i       <= (rand_below(16) == 0) ? (rand_next() & rand_next()) : '0;
        debug_req_i <= (rand_below(24) == 0);
        irq_ack_i   <= (rand_below(6) == 0);
        // Half the acks target the last armed line
        irq_id_i    <= (rand_below(2) == 0) ? last_line : IRQ_ID_W'(rand_below(32));
    endtask

    // Hold the request until it is seen granted
    task automatic issue(input logic [ADDR_W-1:0] addr, input logic we,
                         input logic [DATA_W/8-1:0] be, input logic [DATA_W-1:0] wdata);
        int unsigned waited;
        next_edge();
        req_i   <= 1'b1;
        addr_i  <= addr;
        we_i    <= we;
        be_i    <= be;
        wdata_i <= wdata;
        waited = 0;
        @(negedge clk_i);
        while (!gnt_o && waited < GNT_LIMIT) begin
            next_edge();
            @(negedge clk_i);
            waited++;
        end
        if (!gnt_o) begin
            errors++;
            $display("Error: no grant for address %h within %0d cycles", addr, GNT_LIMIT);
        end
    endtask

    task automatic idle(input int unsigned n);
        repeat (n) begin
            next_edge();
            req_i <= 1'b0;
        end
    endtask

    // ---------------------------------------------------------------
    // Checks and model evaluated between edges
    // ---------------------------------------------------------------
    task automatic check_outputs();
        logic              exp_rvalid;
        logic              exp_gnt;
        logic [DATA_W-1:0] exp_data;
        exp_rvalid = (exp_cyc_q.size() != 0) && (exp_cyc_q[0] + LAT == cyc);
        checks += 4;
        if (rvalid_o !== exp_rvalid) begin
            errors++;
            $display("Error: rvalid_o = %h, expected %h at cycle %0d", rvalid_o, exp_rvalid, cyc);
        end
        // Responses seen on the port
        if (rvalid_o === 1'b1) begin
            resps++;
        end
        if ((rvalid_o || exp_rvalid) && exp_cyc_q.size() != 0) begin
            void'(exp_cyc_q.pop_front());
            exp_data = exp_data_q.pop_front();
            checks++;
            if (rvalid_o && rdata_o !== exp_data) begin
                errors++;
                $display("Error: rdata_o = %h, expected %h at cycle %0d", rdata_o, exp_data, cyc);
            end
        end
        // Free again once the response in flight has been returned
        exp_gnt = req_i && (exp_cyc_q.size() == 0);
        if (gnt_o !== exp_gnt) begin
            errors++;
            $display("Error: gnt_o = %h, expected %h at cycle %0d", gnt_o, exp_gnt, cyc);
        end
        if (irq_o !== (pend_m | irq_i)) begin
            errors++;
            $display("Error: irq_o = %h, expected %h at cycle %0d", irq_o, pend_m | irq_i, cyc);
        end
        if (debug_req_o !== (dbg_m | debug_req_i)) begin
            errors++;
            $display("Error: debug_req_o = %h, expected %h at cycle %0d",
                     debug_req_o, dbg_m | debug_req_i, cyc);
        end
    endtask

    // Advance the model over the coming edge with the visible inputs
    task automatic model_step();
        logic [IRQ_W-1:0]    set_m;
        logic [IRQ_W-1:0]    clr_m;
        logic [IRQ_W-1:0]    ack_m;
        logic [RAM_AW-3:0]   idx;
        int unsigned         edge_n;
        edge_n = cyc + 1;
        set_m  = '0;
        clr_m  = '0;
        ack_m  = '0;
        idx    = addr_i[RAM_AW-1:2];
        if (req_i && gnt_o) begin
            grants++;
            exp_cyc_q.push_back(cyc);
            // Writes and VP reads answer with zero
            if (we_i || addr_i[RAM_AW]) begin
                exp_data_q.push_back('0);
            end else begin
                exp_data_q.push_back(shadow[idx]);
            end
            if (we_i && !addr_i[RAM_AW]) begin
                for (int b = 0; b < DATA_W/8; b++) begin
                    if (be_i[b]) begin
                        shadow[idx][8*b +: 8] = wdata_i[8*b +: 8];
                    end
                end
            end
            if (we_i && addr_i[RAM_AW]) begin
                case (addr_i[3:2])
                    VP_OFFSET_IRQ_TIMER: begin
                        // Delay in the upper half and zero disarms
                        irq_due    = (wdata_i[31:16] == 0) ? 0 : edge_n + wdata_i[31:16];
                        irq_line_m = wdata_i[IRQ_ID_W-1:0];
                    end
                    VP_OFFSET_DEBUG_TIMER: begin
                        dbg_due = (wdata_i[15:0] == 0) ? 0 : edge_n + wdata_i[15:0];
                    end
                    VP_OFFSET_IRQ_CLEAR: begin
                        clr_m = wdata_i;
                    end
                    default: begin
                    end
                endcase
            end
        end
        // Reload above already replaced any countdown due at this edge
        if (irq_due == edge_n) begin
            set_m   = IRQ_W'(1) << irq_line_m;
            irq_due = 0;
        end
        dbg_m = (dbg_due == edge_n);
        if (dbg_m) begin
            dbg_due = 0;
        end
        if (irq_ack_i) begin
            ack_m = IRQ_W'(1) << irq_id_i;
        end
        pend_m = (pend_m & ~clr_m & ~ack_m) | set_m;
    endtask

    always @(negedge clk_i) begin
        cyc = cyc + 1;
        if (arst_n_i) begin
            check_outputs();
            model_step();
        end
    end

    // ---------------------------------------------------------------
    // Test sequence
    // ---------------------------------------------------------------
    initial begin
        logic [31:0] r;
        int unsigned w;
        int unsigned d;
        arst_n_i    = 1'b0;
        req_i       = 1'b0;
        addr_i      = '0;
        we_i        = 1'b0;
        be_i        = '0;
        wdata_i     = '0;
        irq_i       = '0;
        irq_ack_i   = 1'b0;
        irq_id_i    = '0;
        debug_req_i = 1'b0;
        repeat (2) @(posedge clk_i);
        arst_n_i <= 1'b1;
        for (int n = 0; n < N_OPS; n++) begin
            r = rand_next();
            w = rand_below(64);
            d = (r[11:8] == 0) ? 0 : 1 + rand_below(64);
            case (rand_below(16))
                0, 1, 2, 3, 4: begin
                    // First write to a word fills all lanes
                    issue(ADDR_W'(w) << 2, 1'b1, written[w] ? r[3:0] : 4'hF, rand_next());
                    written[w] = 1'b1;
                end
                5, 6, 7, 8: begin
                    // Unwritten word turns into a full write
                    issue(ADDR_W'(w) << 2, !written[w], 4'hF, r);
                    written[w] = 1'b1;
                end
                9, 10: begin
                    last_line = r[IRQ_ID_W-1:0];
                    issue(VP_BASE | (ADDR_W'(VP_OFFSET_IRQ_TIMER) << 2), 1'b1, 4'hF,
                          {d[15:0], r[15:0]});
                end
                11, 12: begin
                    issue(VP_BASE | (ADDR_W'(VP_OFFSET_DEBUG_TIMER) << 2), 1'b1, 4'hF,
                          {r[31:16], d[15:0]});
                end
                13: begin
                    issue(VP_BASE | (ADDR_W'(VP_OFFSET_IRQ_CLEAR) << 2), 1'b1, 4'hF, r);
                end
                default: begin
                    issue(VP_BASE | (ADDR_W'(r[1:0]) << 2), 1'b0, 4'hF, r);
                end
            endcase
            // Mostly back to back and sometimes long enough for timers to fire
            if (rand_below(8) == 0) begin
                idle(1 + rand_below(66));
            end
        end
        // Let the last response and any armed timer finish
        idle(70);
        checks++;
        if (grants != resps) begin
            errors++;
            $display("Error: %0d grants but %0d responses", grants, resps);
        end
        finish_run();
    end

    // Watchdog
    initial begin
        repeat (WATCHDOG) @(posedge clk_i);
        errors++;
        $display("Error: watchdog expired, run did not end within %0d cycles", WATCHDOG);
        finish_run();
    end

endmodule : tb_obi_vp

`default_nettype wire

// ==== src/obi_ram.sv ====
// ---------------------------------------------------------------------
// Byte-enabled word RAM behind the OBI data port
// Writes and the read capture both happen on the accept strobe; the
// captured word is held until the next accepted RAM transaction
// ---------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module obi_ram #(
    parameter int unsigned RAM_ADDR_WIDTH = 12
) (
    input  wire logic                              clk_i,
    input  wire logic                              accept_i,
    input  wire logic                              we_i,
    input  wire logic [obi_vp_pkg::DATA_W/8-1:0]   be_i,
    input  wire logic [RAM_ADDR_WIDTH-1:0]         addr_i,
    input  wire logic [obi_vp_pkg::DATA_W-1:0]     wdata_i,
    output logic      [obi_vp_pkg::DATA_W-1:0]     rdata_o
);

    import obi_vp_pkg::*;

    localparam int unsigned BE_W  = DATA_W / 8;
    localparam int unsigned DEPTH = 2 ** (RAM_ADDR_WIDTH - 2);

    logic [DATA_W-1:0]         mem [DEPTH];
    logic [DATA_W-1:0]         rdata_q;
    logic [RAM_ADDR_WIDTH-3:0] word_idx;

    // Byte offset bits are ignored, accesses are word aligned
    assign word_idx = addr_i[RAM_ADDR_WIDTH-1:2];

    // ---------------------------------------------------------------
    // Byte lane writes
    // ---------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (accept_i && we_i) begin
            for (int b = 0; b < BE_W; b++) begin
                if (be_i[b]) begin
                    mem[word_idx][8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end
        end
    end

    // Read capture, old contents on a same-edge write
    always_ff @(posedge clk_i) begin
        if (accept_i) begin
            rdata_q <= mem[word_idx];
        end
    end

    assign rdata_o = rdata_q;

endmodule : obi_ram

`default_nettype wire

// ==== src/obi_resp_fsm.sv ====
// ---------------------------------------------------------------------
// OBI grant and response timing
// Grants one request at a time and raises rvalid exactly RESP_LATENCY
// cycles after the grant edge; a new grant may overlap the rvalid cycle
// ---------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module obi_resp_fsm #(
    parameter int unsigned RESP_LATENCY = 2
) (
    input  wire logic clk_i,
    input  wire logic arst_n_i,
    input  wire logic req_i,
    output logic      gnt_o,
    output logic      rvalid_o
);

    import obi_vp_pkg::*;

    // Counter holds the remaining WAIT cycles
    localparam int unsigned CNT_W = $clog2(RESP_LATENCY + 1);
    localparam logic [CNT_W-1:0] CNT_LOAD =
        CNT_W'((RESP_LATENCY > 1) ? RESP_LATENCY - 2 : 0);

    resp_state_e      state_q;
    resp_state_e      state_d;
    logic [CNT_W-1:0] cnt_q;
    logic [CNT_W-1:0] cnt_d;

    // Free in IDLE and in the last cycle of a response
    assign gnt_o    = req_i && (state_q != RESP_WAIT);
    assign rvalid_o = (state_q == RESP_VALID);

    // ---------------------------------------------------------------
    // Next state
    // ---------------------------------------------------------------
    always_comb begin
        state_d = state_q;
        cnt_d   = cnt_q;
        case (state_q)
            RESP_IDLE, RESP_VALID: begin
                if (gnt_o) begin
                    // Latency of one skips the wait phase
                    if (RESP_LATENCY == 1) begin
                        state_d = RESP_VALID;
                    end else begin
                        state_d = RESP_WAIT;
                        cnt_d   = CNT_LOAD;
                    end
                end else begin
                    state_d = RESP_IDLE;
                end
            end
            RESP_WAIT: begin
                if (cnt_q == '0) begin
                    state_d = RESP_VALID;
                end else begin
                    cnt_d = cnt_q - 1'b1;
                end
            end
            default: begin
                state_d = RESP_IDLE;
            end
        endcase
    end

    // ---------------------------------------------------------------
    // State registers
    // ---------------------------------------------------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= RESP_IDLE;
            cnt_q   <= '0;
        end else begin
            state_q <= state_d;
            cnt_q   <= cnt_d;
        end
    end

endmodule : obi_resp_fsm

`default_nettype wire

// ==== src/obi_vp_pkg.sv ====
// ---------------------------------------------------------------------
// Shared definitions for the OBI memory and virtual-peripheral block
// Bus widths, the word offsets of the VP register window and the
// state and opcode enums used by the FSM, decoder and timer
// Import inside module bodies, use scoped names in port lists
// ---------------------------------------------------------------------

`default_nettype none

package obi_vp_pkg;

    // ---------------------------------------------------------------
    // Bus widths
    // ---------------------------------------------------------------
    localparam int unsigned ADDR_W   = 32;
    localparam int unsigned DATA_W   = 32;
    localparam int unsigned IRQ_W    = 32;
    localparam int unsigned IRQ_ID_W = 5;

    // Countdown width of both timer channels
    localparam int unsigned TIMER_W  = 16;

    // ---------------------------------------------------------------
    // VP register window, word offsets
    // ---------------------------------------------------------------
    localparam int unsigned VP_OFF_W = 2;

    // Line index in wdata[4:0], delay in wdata[31:16]
    localparam logic [VP_OFF_W-1:0] VP_OFFSET_IRQ_TIMER   = 2'd0;
    // Delay in wdata[15:0]
    localparam logic [VP_OFF_W-1:0] VP_OFFSET_DEBUG_TIMER = 2'd1;
    // Mask of pending lines to drop
    localparam logic [VP_OFF_W-1:0] VP_OFFSET_IRQ_CLEAR   = 2'd2;

    // Response phase of the OBI slave
    typedef enum logic [1:0] {
        RESP_IDLE,
        RESP_WAIT,
        RESP_VALID
    } resp_state_e;

    // Decoded VP write operation
    typedef enum logic [1:0] {
        VP_NONE,
        VP_IRQ_TIMER,
        VP_DEBUG_TIMER,
        VP_IRQ_CLEAR
    } vp_op_e;

endpackage : obi_vp_pkg

`default_nettype wire

// ==== src/obi_vp_top.sv ====
// ---------------------------------------------------------------------
// Memory and virtual peripheral subsystem on one OBI data port
// RAM below address bit RAM_ADDR_WIDTH, VP register window above it;
// VP interrupt and debug requests are ORed with the external ones
// ---------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module obi_vp_top #(
    parameter int unsigned RAM_ADDR_WIDTH = 12,
    parameter int unsigned RESP_LATENCY   = 2
) (
    input  wire logic                            clk_i,
    input  wire logic                            arst_n_i,

    // OBI data port
    input  wire logic                            req_i,
    output logic                                 gnt_o,
    input  wire logic [obi_vp_pkg::ADDR_W-1:0]   addr_i,
    input  wire logic                            we_i,
    input  wire logic [obi_vp_pkg::DATA_W/8-1:0] be_i,
    input  wire logic [obi_vp_pkg::DATA_W-1:0]   wdata_i,
    output logic                                 rvalid_o,
    output logic      [obi_vp_pkg::DATA_W-1:0]   rdata_o,

    // Interrupts
    input  wire logic [obi_vp_pkg::IRQ_W-1:0]    irq_i,
    input  wire logic                            irq_ack_i,
    input  wire logic [obi_vp_pkg::IRQ_ID_W-1:0] irq_id_i,
    output logic      [obi_vp_pkg::IRQ_W-1:0]    irq_o,

    // Debug request
    input  wire logic                            debug_req_i,
    output logic                                 debug_req_o
);

    import obi_vp_pkg::*;

    logic                accept;
    logic                vp_sel;
    logic                ram_accept;
    logic [VP_OFF_W-1:0] vp_off;
    vp_op_e              vp_op;
    logic                rd_ram_q;
    logic [DATA_W-1:0]   ram_rdata;
    logic [IRQ_W-1:0]    irq_set;
    logic [IRQ_W-1:0]    clr_mask;
    logic                dbg_pulse;

    // ---------------------------------------------------------------
    // Address decode
    // ---------------------------------------------------------------
    assign accept     = req_i && gnt_o;
    assign vp_sel     = addr_i[RAM_ADDR_WIDTH];
    assign ram_accept = accept && !vp_sel;
    assign vp_off     = addr_i[VP_OFF_W+1:2];

    // Only writes into the VP window carry an opcode
    always_comb begin
        vp_op = VP_NONE;
        if (vp_sel && we_i) begin
            case (vp_off)
                VP_OFFSET_IRQ_TIMER:   vp_op = VP_IRQ_TIMER;
                VP_OFFSET_DEBUG_TIMER: vp_op = VP_DEBUG_TIMER;
                VP_OFFSET_IRQ_CLEAR:   vp_op = VP_IRQ_CLEAR;
                default:               vp_op = VP_NONE;
            endcase
        end
    end

    // RAM read flag, zero data for writes and VP accesses
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rd_ram_q <= 1'b0;
        end else if (accept) begin
            rd_ram_q <= !vp_sel && !we_i;
        end
    end

    assign rdata_o = rd_ram_q ? ram_rdata : '0;

    // ---------------------------------------------------------------
    // Submodules
    // ---------------------------------------------------------------
    obi_resp_fsm #(
        .RESP_LATENCY (RESP_LATENCY)
    ) obi_resp_fsm_i (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .req_i    (req_i),
        .gnt_o    (gnt_o),
        .rvalid_o (rvalid_o)
    );

    obi_ram #(
        .RAM_ADDR_WIDTH (RAM_ADDR_WIDTH)
    ) obi_ram_i (
        .clk_i    (clk_i),
        .accept_i (ram_accept),
        .we_i     (we_i),
        .be_i     (be_i),
        .addr_i   (addr_i[RAM_ADDR_WIDTH-1:0]),
        .wdata_i  (wdata_i),
        .rdata_o  (ram_rdata)
    );

    vp_timer vp_timer_i (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .accept_i    (accept),
        .op_i        (vp_op),
        .wdata_i     (wdata_i),
        .irq_set_o   (irq_set),
        .clr_mask_o  (clr_mask),
        .dbg_pulse_o (dbg_pulse)
    );

    vp_irq_merge vp_irq_merge_i (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .irq_set_i  (irq_set),
        .clr_mask_i (clr_mask),
        .irq_i      (irq_i),
        .irq_ack_i  (irq_ack_i),
        .irq_id_i   (irq_id_i),
        .irq_o      (irq_o)
    );

    // External debug request passes straight through
    assign debug_req_o = dbg_pulse | debug_req_i;

endmodule : obi_vp_top

`default_nettype wire

// ==== src/vp_irq_merge.sv ====
// ---------------------------------------------------------------------
// Pending interrupt register and external merge
// Timer sets, clear mask and core acknowledge update the pending bits;
// the output is pending OR the external interrupt lines
// ---------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module vp_irq_merge (
    input  wire logic                            clk_i,
    input  wire logic                            arst_n_i,
    input  wire logic [obi_vp_pkg::IRQ_W-1:0]    irq_set_i,
    input  wire logic [obi_vp_pkg::IRQ_W-1:0]    clr_mask_i,
    input  wire logic [obi_vp_pkg::IRQ_W-1:0]    irq_i,
    input  wire logic                            irq_ack_i,
    input  wire logic [obi_vp_pkg::IRQ_ID_W-1:0] irq_id_i,
    output logic      [obi_vp_pkg::IRQ_W-1:0]    irq_o
);

    import obi_vp_pkg::*;

    logic [IRQ_W-1:0] pending_q;
    logic [IRQ_W-1:0] ack_mask;

    // One-hot of the acknowledged line
    assign ack_mask = irq_ack_i ? (IRQ_W'(1) << irq_id_i) : '0;

    // ---------------------------------------------------------------
    // Pending bits, set beats clear
    // ---------------------------------------------------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pending_q <= '0;
        end else begin
            pending_q <= (pending_q & ~clr_mask_i & ~ack_mask) | irq_set_i;
        end
    end

    // External lines pass through, never latched
    assign irq_o = pending_q | irq_i;

endmodule : vp_irq_merge

`default_nettype wire

// ==== src/vp_timer.sv ====
// ---------------------------------------------------------------------
// Virtual peripheral timers
// Two countdown channels loaded by VP writes: one sets an interrupt
// line on expiry, the other pulses a debug request; also forwards the
// interrupt clear mask for one cycle
// ---------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module vp_timer (
    input  wire logic                          clk_i,
    input  wire logic                          arst_n_i,
    input  wire logic                          accept_i,
    input  wire obi_vp_pkg::vp_op_e            op_i,
    input  wire logic [obi_vp_pkg::DATA_W-1:0] wdata_i,
    output logic      [obi_vp_pkg::IRQ_W-1:0]  irq_set_o,
    output logic      [obi_vp_pkg::IRQ_W-1:0]  clr_mask_o,
    output logic                               dbg_pulse_o
);

    import obi_vp_pkg::*;

    logic                irq_load;
    logic                dbg_load;
    logic                clr_hit;
    logic [TIMER_W-1:0]  irq_cnt_q;
    logic [IRQ_ID_W-1:0] irq_line_q;
    logic                irq_fire;
    logic [TIMER_W-1:0]  dbg_cnt_q;
    logic                dbg_pulse_q;

    // Opcode decode of accepted writes
    assign irq_load = accept_i && (op_i == VP_IRQ_TIMER);
    assign dbg_load = accept_i && (op_i == VP_DEBUG_TIMER);
    assign clr_hit  = accept_i && (op_i == VP_IRQ_CLEAR);

    // ---------------------------------------------------------------
    // Interrupt channel
    // ---------------------------------------------------------------
    // Counter value D after the load edge, reaches 1 one cycle early
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            irq_cnt_q <= '0;
        end else if (irq_load) begin
            // Zero delay leaves the channel disarmed
            irq_cnt_q <= wdata_i[DATA_W-1 -: TIMER_W];
        end else if (irq_cnt_q != '0) begin
            irq_cnt_q <= irq_cnt_q - 1'b1;
        end
    end

    // Line index travels with the delay
    always_ff @(posedge clk_i) begin
        if (irq_load) begin
            irq_line_q <= wdata_i[IRQ_ID_W-1:0];
        end
    end

    // A reload in the expiry cycle cancels the old countdown
    assign irq_fire  = (irq_cnt_q == TIMER_W'(1)) && !irq_load;
    assign irq_set_o = irq_fire ? (IRQ_W'(1) << irq_line_q) : '0;

    // ---------------------------------------------------------------
    // Debug channel
    // ---------------------------------------------------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            dbg_cnt_q   <= '0;
            dbg_pulse_q <= 1'b0;
        end else begin
            // Registered so the pulse lines up with the pending bit timing
            dbg_pulse_q <= (dbg_cnt_q == TIMER_W'(1)) && !dbg_load;
            if (dbg_load) begin
                dbg_cnt_q <= wdata_i[TIMER_W-1:0];
            end else if (dbg_cnt_q != '0) begin
                dbg_cnt_q <= dbg_cnt_q - 1'b1;
            end
        end
    end

    assign dbg_pulse_o = dbg_pulse_q;

    // Clear mask is only live in the accept cycle
    assign clr_mask_o = clr_hit ? wdata_i[IRQ_W-1:0] : '0;

endmodule : vp_timer

`default_nettype wire
